// ==== Bender.yml ====
package:
  name: afu_csr

sources:
  - files:
      - csr_pkg.sv
      - csr_bus_fsm.sv
      - csr_test_regs.sv
      - csr_queue_regs.sv
      - csr_debug_window.sv
      - csr_read_mux.sv
      - afu_csr_top.sv
  - target: test
    files:
      - afu_csr_props.sv
      - tb_clock_gen.sv
      - tb_afu_csr.sv

// ==== afu_csr_props.sv ====
`default_nettype none

module afu_csr_props (
   input wire clk,
   input wire reset_n,
   input wire read,
   input wire write,
   input wire waitrequest,
   input wire readdatavalid,
   input wire start_proc,
   input wire end_proc,
   input wire update,
   input wire host_buf_addr_valid [csr_pkg::NUM_CH]
);

   // read data only ever shows up in the ack cycle
   assert property (@(posedge clk) disable iff (!reset_n) readdatavalid |-> !waitrequest)
      else $error("readdatavalid while waitrequest is high");

   assert property (@(posedge clk) disable iff (!reset_n) !waitrequest |=> waitrequest)
      else $error("waitrequest low for more than one cycle");

   assert property (@(posedge clk) disable iff (!reset_n)
                    (read && !write && waitrequest) |=> readdatavalid)
      else $error("read accepted in idle but no readdatavalid");

   assert property (@(posedge clk) disable iff (!reset_n) readdatavalid |-> $past(read))
      else $error("readdatavalid without a read request");

   assert property (@(posedge clk) disable iff (!reset_n) start_proc |=> !start_proc)
      else $error("start_proc longer than one cycle");
   assert property (@(posedge clk) disable iff (!reset_n) end_proc |=> !end_proc)
      else $error("end_proc longer than one cycle");
   assert property (@(posedge clk) disable iff (!reset_n) update |=> !update)
      else $error("update longer than one cycle");

   for (genvar k = 0; k < csr_pkg::NUM_CH; k++) begin : g_hb_pulse
      assert property (@(posedge clk) disable iff (!reset_n)
                       host_buf_addr_valid[k] |=> !host_buf_addr_valid[k])
         else $error("host_buf_addr_valid[%0d] longer than one cycle", k);
   end

endmodule

bind afu_csr_top afu_csr_props i_props (
   .clk                 (clk),
   .reset_n             (reset_n),
   .read                (read),
   .write               (write),
   .waitrequest         (waitrequest),
   .readdatavalid       (readdatavalid),
   .start_proc          (start_proc),
   .end_proc            (end_proc),
   .update              (update),
   .host_buf_addr_valid (host_buf_addr_valid)
);

`default_nettype wire

// ==== afu_csr_top.sv ====
`default_nettype none

module afu_csr_top (
   input  wire                     clk,
   input  wire                     reset_n,
   // Avalon-MM slave
   input  wire                     read,
   input  wire                     write,
   input  wire csr_pkg::csr_addr_t address,
   input  wire csr_pkg::csr_data_t writedata,
   input  wire csr_pkg::csr_be_t   byteenable,
   output csr_pkg::csr_data_t      readdata,
   output logic                    readdatavalid,
   output logic                    waitrequest,
   // test control
   output logic                    start_proc,
   output logic                    end_proc,
   output logic                    update,
   output csr_pkg::csr_data_t      page_addr,
   output csr_pkg::csr_data_t      test_case,
   output csr_pkg::csr_data_t      requester_id,
   output csr_pkg::csr_data_t      block_index_offset,
   output csr_pkg::csr_data_t      write_data [csr_pkg::NUM_DATA],
   input  wire csr_pkg::csr_data_t read_data [csr_pkg::NUM_DATA],
   // storage queues
   output csr_pkg::csr_data_t      bar_addr,
   output csr_pkg::csr_data_t      sq_addr [csr_pkg::NUM_CH],
   output csr_pkg::csr_data_t      cq_addr [csr_pkg::NUM_CH],
   output csr_pkg::csr_data_t      sq_tail [csr_pkg::NUM_CH],
   output csr_pkg::csr_data_t      cq_head [csr_pkg::NUM_CH],
   output csr_pkg::csr_data_t      host_buf_addr [csr_pkg::NUM_CH],
   output logic                    host_buf_addr_valid [csr_pkg::NUM_CH],
   // perf counters
   input  wire csr_pkg::csr_data_t debug_pf [csr_pkg::NUM_DEBUG]
);

   csr_pkg::csr_data_t wdata_masked;  // disabled bytes stored as zero
   logic               wr_en;
   logic               rd_en;
   logic               test_hit;
   csr_pkg::csr_data_t test_value;
   logic               queue_hit;
   csr_pkg::csr_data_t queue_value;
   logic               debug_hit;
   csr_pkg::csr_data_t debug_value;

   assign wdata_masked = writedata & csr_pkg::be_mask(byteenable);

   csr_bus_fsm i_bus_fsm (
      .clk           (clk),
      .reset_n       (reset_n),
      .read          (read),
      .write         (write),
      .waitrequest   (waitrequest),
      .readdatavalid (readdatavalid),
      .wr_en         (wr_en),
      .rd_en         (rd_en)
   );

   csr_test_regs i_test_regs (
      .clk                (clk),
      .reset_n            (reset_n),
      .wr_en              (wr_en),
      .address            (address),
      .wdata_masked       (wdata_masked),
      .read_data          (read_data),
      .start_proc         (start_proc),
      .end_proc           (end_proc),
      .update             (update),
      .page_addr          (page_addr),
      .test_case          (test_case),
      .requester_id       (requester_id),
      .block_index_offset (block_index_offset),
      .write_data         (write_data),
      .rd_hit             (test_hit),
      .rd_value           (test_value)
   );

   csr_queue_regs i_queue_regs (
      .clk                 (clk),
      .reset_n             (reset_n),
      .wr_en               (wr_en),
      .address             (address),
      .wdata_masked        (wdata_masked),
      .bar_addr            (bar_addr),
      .sq_addr             (sq_addr),
      .cq_addr             (cq_addr),
      .sq_tail             (sq_tail),
      .cq_head             (cq_head),
      .host_buf_addr       (host_buf_addr),
      .host_buf_addr_valid (host_buf_addr_valid),
      .rd_hit              (queue_hit),
      .rd_value            (queue_value)
   );

   csr_debug_window i_debug_window (
      .clk      (clk),
      .address  (address),
      .debug_pf (debug_pf),
      .rd_hit   (debug_hit),
      .rd_value (debug_value)
   );

   csr_read_mux i_read_mux (
      .clk         (clk),
      .reset_n     (reset_n),
      .rd_en       (rd_en),
      .byteenable  (byteenable),
      .test_hit    (test_hit),
      .test_value  (test_value),
      .queue_hit   (queue_hit),
      .queue_value (queue_value),
      .debug_hit   (debug_hit),
      .debug_value (debug_value),
      .readdata    (readdata)
   );

endmodule

`default_nettype wire

// ==== csr_bus_fsm.sv ====
`default_nettype none

module csr_bus_fsm (
   input  wire  clk,
   input  wire  reset_n,
   input  wire  read,
   input  wire  write,
   output logic waitrequest,
   output logic readdatavalid,
   output logic wr_en,
   output logic rd_en
);

   csr_pkg::bus_state_t state;
   csr_pkg::bus_state_t next_state;

   always_comb begin
      next_state = csr_pkg::idle;
      case (state)
         csr_pkg::idle: begin
            if (write) begin
               next_state = csr_pkg::write_ack;  // write wins over read
            end else if (read) begin
               next_state = csr_pkg::read_ack;
            end
         end
         default: next_state = csr_pkg::idle;  // every ack lasts one cycle
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state <= csr_pkg::idle;
      end else begin
         state <= next_state;
      end
   end

   assign waitrequest   = (state == csr_pkg::idle);
   assign readdatavalid = (state == csr_pkg::read_ack);

   // banks commit at the end of the ack cycle
   assign wr_en = (state == csr_pkg::write_ack) && write;
   // read mux captures at the end of the request cycle
   assign rd_en = (state == csr_pkg::idle) && read && !write;

endmodule

`default_nettype wire

// ==== csr_debug_window.sv ====
`default_nettype none

module csr_debug_window (
   input  wire                     clk,
   input  wire csr_pkg::csr_addr_t address,
   input  wire csr_pkg::csr_data_t debug_pf [csr_pkg::NUM_DEBUG],
   output logic                    rd_hit,
   output csr_pkg::csr_data_t      rd_value
);

   csr_pkg::csr_data_t                     debug_q [csr_pkg::NUM_DEBUG];
   csr_pkg::csr_addr_t                     dbg_ofs;
   logic [$clog2(csr_pkg::NUM_DEBUG)-1:0]  dbg_idx;

   // counters run freely, snapshot every cycle
   always_ff @(posedge clk) begin
      debug_q <= debug_pf;
   end

   assign dbg_ofs = address - csr_pkg::ADDR_DEBUG;
   assign dbg_idx = dbg_ofs[3 +: $bits(dbg_idx)];  // byte offset / 8

   assign rd_hit = (address >= csr_pkg::ADDR_DEBUG)
                && (address < csr_pkg::csr_addr_t'(csr_pkg::ADDR_DEBUG
                                                   + csr_pkg::NUM_DEBUG * csr_pkg::ADDR_STRIDE));

   assign rd_value = debug_q[dbg_idx];  // gated by rd_hit in the read mux

endmodule

`default_nettype wire

// ==== csr_pkg.sv ====
`default_nettype none

package csr_pkg;

   localparam int NUM_CH    = 4;   // storage channels
   localparam int NUM_DATA  = 8;   // write-data and read-data words
   localparam int NUM_DEBUG = 16;  // debug perf counters

   typedef logic [63:0]               csr_data_t;
   typedef logic [21:0]               csr_addr_t;  // byte address
   typedef logic [7:0]                csr_be_t;
   typedef logic [$clog2(NUM_CH)-1:0] ch_idx_t;

   typedef enum logic [1:0] {
      idle,
      write_ack,
      read_ack
   } bus_state_t;

   // command register codes
   localparam csr_data_t CMD_START  = 64'd1;
   localparam csr_data_t CMD_END    = 64'd2;
   localparam csr_data_t CMD_UPDATE = 64'd3;

   localparam csr_addr_t ADDR_STRIDE    = 22'h008;  // one 64-bit word
   localparam csr_addr_t ADDR_CMD       = 22'h000;
   localparam csr_addr_t ADDR_PAGE      = 22'h008;
   localparam csr_addr_t ADDR_TEST_CASE = 22'h010;
   localparam csr_addr_t ADDR_REQ_ID    = 22'h018;
   localparam csr_addr_t ADDR_BLOCK_OFS = 22'h020;
   localparam csr_addr_t ADDR_RD_DATA   = 22'h030;  // base of read-data words
   localparam csr_addr_t ADDR_WR_DATA   = 22'h070;  // base of write-data words
   localparam csr_addr_t ADDR_SQ_ADDR   = 22'h0d0;
   localparam csr_addr_t ADDR_CQ_ADDR   = 22'h0d8;
   localparam csr_addr_t ADDR_BAR       = 22'h0e0;
   localparam csr_addr_t ADDR_SQ_TAIL   = 22'h0e8;
   localparam csr_addr_t ADDR_CQ_HEAD   = 22'h0f0;
   localparam csr_addr_t ADDR_HOST_BUF  = 22'h108;
   localparam csr_addr_t ADDR_QUEUE_IDX = 22'h110;
   localparam csr_addr_t ADDR_DEBUG     = 22'h228;  // base of debug window

   localparam csr_data_t REQ_ID_RESET = 64'h2a;

   // expands each byte enable bit to a full byte
   function automatic csr_data_t be_mask(input csr_be_t be);
      csr_data_t m;
      for (int i = 0; i < $bits(csr_be_t); i++) begin
         m[8*i +: 8] = {8{be[i]}};
      end
      return m;
   endfunction

endpackage

`default_nettype wire

// ==== csr_queue_regs.sv ====
`default_nettype none

module csr_queue_regs (
   input  wire                     clk,
   input  wire                     reset_n,
   input  wire                     wr_en,
   input  wire csr_pkg::csr_addr_t address,
   input  wire csr_pkg::csr_data_t wdata_masked,
   output csr_pkg::csr_data_t      bar_addr,
   output csr_pkg::csr_data_t      sq_addr [csr_pkg::NUM_CH],
   output csr_pkg::csr_data_t      cq_addr [csr_pkg::NUM_CH],
   output csr_pkg::csr_data_t      sq_tail [csr_pkg::NUM_CH],
   output csr_pkg::csr_data_t      cq_head [csr_pkg::NUM_CH],
   output csr_pkg::csr_data_t      host_buf_addr [csr_pkg::NUM_CH],
   output logic                    host_buf_addr_valid [csr_pkg::NUM_CH],
   output logic                    rd_hit,
   output csr_pkg::csr_data_t      rd_value
);

   csr_pkg::csr_data_t queue_idx;  // full word kept for readback
   csr_pkg::ch_idx_t   ch;
   logic               host_buf_wr;

   assign ch          = queue_idx[$bits(csr_pkg::ch_idx_t)-1:0];  // upper bits ignored
   assign host_buf_wr = wr_en && (address == csr_pkg::ADDR_HOST_BUF);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         queue_idx <= '0;
         bar_addr  <= '0;
         for (int k = 0; k < csr_pkg::NUM_CH; k++) begin
            sq_addr[k]             <= '0;
            cq_addr[k]             <= '0;
            sq_tail[k]             <= '0;
            cq_head[k]             <= '0;
            host_buf_addr[k]       <= '0;
            host_buf_addr_valid[k] <= 1'b0;
         end
      end else begin
         // one-cycle valid, only on the selected channel
         for (int k = 0; k < csr_pkg::NUM_CH; k++) begin
            host_buf_addr_valid[k] <= host_buf_wr && (ch == csr_pkg::ch_idx_t'(k));
         end
         if (wr_en) begin
            case (address)
               csr_pkg::ADDR_SQ_ADDR:   sq_addr[ch]       <= wdata_masked;
               csr_pkg::ADDR_CQ_ADDR:   cq_addr[ch]       <= wdata_masked;
               csr_pkg::ADDR_BAR:       bar_addr          <= wdata_masked;  // shared
               csr_pkg::ADDR_SQ_TAIL:   sq_tail[ch]       <= wdata_masked;
               csr_pkg::ADDR_CQ_HEAD:   cq_head[ch]       <= wdata_masked;
               csr_pkg::ADDR_HOST_BUF:  host_buf_addr[ch] <= wdata_masked;
               csr_pkg::ADDR_QUEUE_IDX: queue_idx         <= wdata_masked;
               default: ;
            endcase
         end
      end
   end

   // per-channel reads follow the same queue index
   always_comb begin
      rd_hit   = 1'b1;
      rd_value = '0;
      case (address)
         csr_pkg::ADDR_SQ_ADDR:   rd_value = sq_addr[ch];
         csr_pkg::ADDR_CQ_ADDR:   rd_value = cq_addr[ch];
         csr_pkg::ADDR_BAR:       rd_value = bar_addr;
         csr_pkg::ADDR_SQ_TAIL:   rd_value = sq_tail[ch];
         csr_pkg::ADDR_CQ_HEAD:   rd_value = cq_head[ch];
         csr_pkg::ADDR_HOST_BUF:  rd_value = host_buf_addr[ch];
         csr_pkg::ADDR_QUEUE_IDX: rd_value = queue_idx;
         default:                 rd_hit   = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

// ==== csr_read_mux.sv ====
`default_nettype none

module csr_read_mux (
   input  wire                     clk,
   input  wire                     reset_n,
   input  wire                     rd_en,
   input  wire csr_pkg::csr_be_t   byteenable,
   input  wire                     test_hit,
   input  wire csr_pkg::csr_data_t test_value,
   input  wire                     queue_hit,
   input  wire csr_pkg::csr_data_t queue_value,
   input  wire                     debug_hit,
   input  wire csr_pkg::csr_data_t debug_value,
   output csr_pkg::csr_data_t      readdata
);

   csr_pkg::csr_data_t mask;
   csr_pkg::csr_data_t sel_value;

   assign mask = csr_pkg::be_mask(byteenable);

   // banks never overlap, so an and-or select is enough; zero when nobody hits
   assign sel_value = (test_hit  ? test_value  : '0)
                    | (queue_hit ? queue_value : '0)
                    | (debug_hit ? debug_value : '0);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         readdata <= '0;
      end else if (rd_en) begin
         readdata <= sel_value & mask;  // held through the read_ack cycle
      end
   end

endmodule

`default_nettype wire

// ==== csr_test_regs.sv ====
`default_nettype none

module csr_test_regs (
   input  wire                     clk,
   input  wire                     reset_n,
   input  wire                     wr_en,
   input  wire csr_pkg::csr_addr_t address,
   input  wire csr_pkg::csr_data_t wdata_masked,
   input  wire csr_pkg::csr_data_t read_data [csr_pkg::NUM_DATA],
   output logic                    start_proc,
   output logic                    end_proc,
   output logic                    update,
   output csr_pkg::csr_data_t      page_addr,
   output csr_pkg::csr_data_t      test_case,
   output csr_pkg::csr_data_t      requester_id,
   output csr_pkg::csr_data_t      block_index_offset,
   output csr_pkg::csr_data_t      write_data [csr_pkg::NUM_DATA],
   output logic                    rd_hit,
   output csr_pkg::csr_data_t      rd_value
);

   csr_pkg::csr_data_t           cmd_reg;                       // last command written
   csr_pkg::csr_data_t           read_data_q [csr_pkg::NUM_DATA];
   logic                         cmd_wr;
   logic [csr_pkg::NUM_DATA-1:0] wd_sel;                        // address is write-data word i
   logic [csr_pkg::NUM_DATA-1:0] rdd_sel;                       // address is read-data word i

   assign cmd_wr = wr_en && (address == csr_pkg::ADDR_CMD);

   always_comb begin
      for (int i = 0; i < csr_pkg::NUM_DATA; i++) begin
         wd_sel[i]  = (address == csr_pkg::csr_addr_t'(csr_pkg::ADDR_WR_DATA
                                                       + i * csr_pkg::ADDR_STRIDE));
         rdd_sel[i] = (address == csr_pkg::csr_addr_t'(csr_pkg::ADDR_RD_DATA
                                                       + i * csr_pkg::ADDR_STRIDE));
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         cmd_reg            <= '0;
         page_addr          <= '0;
         test_case          <= '0;
         requester_id       <= csr_pkg::REQ_ID_RESET;
         block_index_offset <= '0;
         start_proc         <= 1'b0;
         end_proc           <= 1'b0;
         update             <= 1'b0;
         for (int i = 0; i < csr_pkg::NUM_DATA; i++) begin
            write_data[i] <= '0;
         end
      end else begin
         // pulses drop again unless the next cycle also commits a command
         start_proc <= cmd_wr && (wdata_masked == csr_pkg::CMD_START);
         end_proc   <= cmd_wr && (wdata_masked == csr_pkg::CMD_END);
         update     <= cmd_wr && (wdata_masked == csr_pkg::CMD_UPDATE);
         if (wr_en) begin
            case (address)
               csr_pkg::ADDR_CMD:       cmd_reg            <= wdata_masked;
               csr_pkg::ADDR_PAGE:      page_addr          <= wdata_masked;
               csr_pkg::ADDR_TEST_CASE: test_case          <= wdata_masked;
               csr_pkg::ADDR_REQ_ID:    requester_id       <= wdata_masked;
               csr_pkg::ADDR_BLOCK_OFS: block_index_offset <= wdata_masked;
               default: ;
            endcase
            for (int i = 0; i < csr_pkg::NUM_DATA; i++) begin
               if (wd_sel[i]) begin
                  write_data[i] <= wdata_masked;
               end
            end
         end
      end
   end

   // read-only words from the datapath, sampled every cycle
   always_ff @(posedge clk) begin
      read_data_q <= read_data;
   end

   always_comb begin
      rd_hit   = 1'b1;
      rd_value = '0;
      case (address)
         csr_pkg::ADDR_CMD:       rd_value = cmd_reg;
         csr_pkg::ADDR_PAGE:      rd_value = page_addr;
         csr_pkg::ADDR_TEST_CASE: rd_value = test_case;
         csr_pkg::ADDR_REQ_ID:    rd_value = requester_id;
         csr_pkg::ADDR_BLOCK_OFS: rd_value = block_index_offset;
         default:                 rd_hit   = 1'b0;
      endcase
      for (int i = 0; i < csr_pkg::NUM_DATA; i++) begin
         if (wd_sel[i]) begin
            rd_hit   = 1'b1;
            rd_value = write_data[i];
         end
         if (rdd_sel[i]) begin
            rd_hit   = 1'b1;
            rd_value = read_data_q[i];
         end
      end
   end

endmodule

`default_nettype wire

// ==== sim.f ====
csr_pkg.sv
csr_bus_fsm.sv
csr_test_regs.sv
csr_queue_regs.sv
csr_debug_window.sv
csr_read_mux.sv
afu_csr_top.sv
afu_csr_props.sv
tb_clock_gen.sv
tb_afu_csr.sv

// ==== tb_afu_csr.sv ====
`default_nettype none

module tb_afu_csr;

   wire                clk;
   logic               reset_n;
   logic               read;
   logic               write;
   csr_pkg::csr_addr_t address;
   csr_pkg::csr_data_t writedata;
   csr_pkg::csr_be_t   byteenable;
   csr_pkg::csr_data_t readdata;
   logic               readdatavalid;
   logic               waitrequest;
   logic               start_proc;
   logic               end_proc;
   logic               update;
   csr_pkg::csr_data_t page_addr;
   csr_pkg::csr_data_t test_case;
   csr_pkg::csr_data_t requester_id;
   csr_pkg::csr_data_t block_index_offset;
   csr_pkg::csr_data_t write_data [csr_pkg::NUM_DATA];
   csr_pkg::csr_data_t read_data [csr_pkg::NUM_DATA];
   csr_pkg::csr_data_t bar_addr;
   csr_pkg::csr_data_t sq_addr [csr_pkg::NUM_CH];
   csr_pkg::csr_data_t cq_addr [csr_pkg::NUM_CH];
   csr_pkg::csr_data_t sq_tail [csr_pkg::NUM_CH];
   csr_pkg::csr_data_t cq_head [csr_pkg::NUM_CH];
   csr_pkg::csr_data_t host_buf_addr [csr_pkg::NUM_CH];
   logic               host_buf_addr_valid [csr_pkg::NUM_CH];
   csr_pkg::csr_data_t debug_pf [csr_pkg::NUM_DEBUG];

   int                 seed = 26832;
   int                 errors = 0;
   int                 checks = 0;
   int                 test_errs;
   int                 start_cnt = 0;
   int                 end_cnt = 0;
   int                 update_cnt = 0;
   int                 hb_cnt [csr_pkg::NUM_CH];
   int                 s0;
   int                 e0;
   int                 u0;
   csr_pkg::csr_data_t pending_exp [$];   // expected readdata, oldest first
   csr_pkg::csr_addr_t pending_addr [$];
   csr_pkg::csr_data_t exp_word;
   csr_pkg::csr_addr_t exp_addr;
   csr_pkg::csr_data_t data;
   csr_pkg::csr_data_t code;
   csr_pkg::csr_data_t got;
   csr_pkg::csr_data_t bar_exp;
   csr_pkg::csr_data_t qreg [5][csr_pkg::NUM_CH];  // sq, cq, tail, head, host buf
   csr_pkg::csr_addr_t addr;
   csr_pkg::csr_be_t   be_w;
   csr_pkg::csr_be_t   be_r;

   tb_clock_gen i_clk_gen (.clk(clk));

   afu_csr_top i_dut (.*);

   // byte survives only if enabled on both the write and the read
   function automatic csr_pkg::csr_data_t expected_read(input csr_pkg::csr_data_t written,
                                                        input csr_pkg::csr_be_t be_w,
                                                        input csr_pkg::csr_be_t be_r,
                                                        input bit mapped);
      csr_pkg::csr_data_t result;
      result = '0;
      for (int b = 0; b < 8; b++) begin
         if (mapped && be_w[b] && be_r[b]) begin
            result[8*b +: 8] = written[8*b +: 8];
         end
      end
      return result;
   endfunction

   function automatic csr_pkg::csr_addr_t queue_addr(input int j);
      case (j)
         0:       return 22'h0d0;
         1:       return 22'h0d8;
         2:       return 22'h0e8;
         3:       return 22'h0f0;
         default: return 22'h108;
      endcase
   endfunction

   function automatic csr_pkg::csr_data_t queue_port(input int j, input int k);
      case (j)
         0:       return sq_addr[k];
         1:       return cq_addr[k];
         2:       return sq_tail[k];
         3:       return cq_head[k];
         default: return host_buf_addr[k];
      endcase
   endfunction

   task automatic check_value(input string name, input csr_pkg::csr_data_t got,
                              input csr_pkg::csr_data_t exp);
      checks++;
      assert (got === exp) else begin
         $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic wait_ack(input string what);
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (waitrequest && cycles < 20) begin
         @(negedge clk);
         cycles++;
      end
      if (waitrequest) begin
         $display("timeout at %0t: waitrequest never went low for a %s", $time, what);
         $display("Simulation failed");
         $finish;
      end
   endtask

   task automatic bus_write(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_data_t wd,
                            input csr_pkg::csr_be_t be);
      write      = 1'b1;
      address    = addr;
      writedata  = wd;
      byteenable = be;
      wait_ack("write");
      @(negedge clk);  // commit edge has passed
      write = 1'b0;
   endtask

   task automatic bus_read(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_be_t be,
                           input csr_pkg::csr_data_t exp);
      pending_exp.push_back(exp);
      pending_addr.push_back(addr);
      read       = 1'b1;
      address    = addr;
      byteenable = be;
      wait_ack("read");
      @(negedge clk);
      read = 1'b0;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic report_test(input string name, input int errs_before);
      $display("test %s finished with %0d errors", name, errors - errs_before);
   endtask

   // compare each returned word with the oldest pending expectation
   always @(negedge clk) begin
      if (readdatavalid) begin
         checks++;
         assert (pending_exp.size() > 0) else begin
            $display("readdatavalid at %0t came with no read pending", $time);
            errors++;
         end
         if (pending_exp.size() > 0) begin
            exp_word = pending_exp.pop_front();
            exp_addr = pending_addr.pop_front();
            assert (readdata === exp_word) else begin
               $display("Fail at %0t: readdata (address %h) is %h, expected %h",
                        $time, exp_addr, readdata, exp_word);
               errors++;
            end
         end
      end
   end

   // one sample per cycle, so a one-cycle pulse counts once
   always @(negedge clk) begin
      if (reset_n) begin
         start_cnt  += int'(start_proc);
         end_cnt    += int'(end_proc);
         update_cnt += int'(update);
         for (int k = 0; k < csr_pkg::NUM_CH; k++) begin
            hb_cnt[k] += int'(host_buf_addr_valid[k]);
         end
      end
   end

   initial begin
      reset_n    = 1'b0;
      read       = 1'b0;
      write      = 1'b0;
      address    = '0;
      writedata  = '0;
      byteenable = '0;
      for (int i = 0; i < csr_pkg::NUM_DATA; i++) begin
         read_data[i] = '0;
      end
      for (int i = 0; i < csr_pkg::NUM_DEBUG; i++) begin
         debug_pf[i] = '0;
      end
      for (int k = 0; k < csr_pkg::NUM_CH; k++) begin
         hb_cnt[k] = 0;
      end
      repeat (3) @(negedge clk);
      reset_n = 1'b1;
      idle_cycles(1);

      test_errs = errors;
      check_value("waitrequest", 64'(waitrequest), 64'd1);
      check_value("start_proc", 64'(start_proc), 64'd0);
      check_value("end_proc", 64'(end_proc), 64'd0);
      check_value("update", 64'(update), 64'd0);
      for (int k = 0; k < csr_pkg::NUM_CH; k++) begin
         check_value($sformatf("host_buf_addr_valid[%0d]", k), 64'(host_buf_addr_valid[k]), 0);
      end
      check_value("requester_id", requester_id, 64'h2a);
      bus_read(22'h018, 8'hff, expected_read(64'h2a, 8'hff, 8'hff, 1'b1));
      bus_read(22'h008, 8'hff, expected_read(64'h0, 8'hff, 8'hff, 1'b1));
      report_test("reset", test_errs);

      test_errs = errors;
      for (int i = 0; i < 3 + csr_pkg::NUM_DATA; i++) begin
         case (i)
            0:       addr = 22'h008;
            1:       addr = 22'h010;
            2:       addr = 22'h020;
            default: addr = csr_pkg::csr_addr_t'(22'h070 + 8 * (i - 3));
         endcase
         data = {$random(seed), $random(seed)};
         be_w = csr_pkg::csr_be_t'($random(seed));
         be_r = csr_pkg::csr_be_t'($random(seed));
         bus_write(addr, data, be_w);
         case (i)
            0:       got = page_addr;
            1:       got = test_case;
            2:       got = block_index_offset;
            default: got = write_data[i-3];
         endcase
         check_value($sformatf("port of %h", addr), got, expected_read(data, be_w, 8'hff, 1'b1));
         bus_read(addr, be_r, expected_read(data, be_w, be_r, 1'b1));
      end
      report_test("byte enables", test_errs);

      test_errs = errors;
      for (int c = 0; c < 4; c++) begin
         code = (c == 3) ? 64'd5 : 64'(c + 1);  // last one is no command
         s0 = start_cnt;
         e0 = end_cnt;
         u0 = update_cnt;
         bus_write(22'h000, code, 8'hff);
         idle_cycles(2);
         check_value("start_proc pulses", 64'(start_cnt - s0), 64'(code == 64'd1));
         check_value("end_proc pulses", 64'(end_cnt - e0), 64'(code == 64'd2));
         check_value("update pulses", 64'(update_cnt - u0), 64'(code == 64'd3));
      end
      bus_read(22'h000, 8'hff, expected_read(64'd5, 8'hff, 8'hff, 1'b1));
      report_test("commands", test_errs);

      test_errs = errors;
      for (int k = 0; k < csr_pkg::NUM_CH; k++) begin
         bus_write(22'h110, 64'(k), 8'hff);
         for (int j = 0; j < 5; j++) begin
            qreg[j][k] = {$random(seed), $random(seed)};
            bus_write(queue_addr(j), qreg[j][k], 8'hff);
         end
         bar_exp = {$random(seed), $random(seed)};  // shared, last write wins
         bus_write(22'h0e0, bar_exp, 8'hff);
         // channels up to k have seen exactly one valid pulse so far
         for (int m = 0; m < csr_pkg::NUM_CH; m++) begin
            check_value($sformatf("host_buf_addr_valid[%0d] pulses", m), 64'(hb_cnt[m]),
                        64'(m <= k));
         end
      end
      idle_cycles(2);
      for (int k = 0; k < csr_pkg::NUM_CH; k++) begin
         bus_write(22'h110, 64'(k), 8'hff);
         for (int j = 0; j < 5; j++) begin
            check_value($sformatf("queue port %0d of channel %0d", j, k), queue_port(j, k),
                        qreg[j][k]);
            bus_read(queue_addr(j), 8'hff, qreg[j][k]);
         end
         bus_read(22'h0e0, 8'hff, bar_exp);
      end
      check_value("bar_addr", bar_addr, bar_exp);
      report_test("queues", test_errs);

      test_errs = errors;
      for (int i = 0; i < csr_pkg::NUM_DATA; i++) begin
         read_data[i] = {$random(seed), $random(seed)};
      end
      for (int i = 0; i < csr_pkg::NUM_DEBUG; i++) begin
         debug_pf[i] = {$random(seed), $random(seed)};
      end
      idle_cycles(2);
      for (int i = 0; i < csr_pkg::NUM_DATA; i++) begin
         be_r = csr_pkg::csr_be_t'($random(seed));
         bus_read(csr_pkg::csr_addr_t'(22'h030 + 8 * i), be_r,
                  expected_read(read_data[i], 8'hff, be_r, 1'b1));
      end
      for (int i = 0; i < csr_pkg::NUM_DEBUG; i++) begin
         be_r = csr_pkg::csr_be_t'($random(seed));
         bus_read(csr_pkg::csr_addr_t'(22'h228 + 8 * i), be_r,
                  expected_read(debug_pf[i], 8'hff, be_r, 1'b1));
      end
      bus_read(22'h028, 8'hff, expected_read(64'hffff_ffff_ffff_ffff, 8'hff, 8'hff, 1'b0));
      bus_read(22'h400, 8'hff, expected_read(64'hffff_ffff_ffff_ffff, 8'hff, 8'hff, 1'b0));
      bus_read(22'h2a8, 8'hff, expected_read(64'hffff_ffff_ffff_ffff, 8'hff, 8'hff, 1'b0));
      report_test("read-only windows", test_errs);

      idle_cycles(4);
      checks++;
      assert (pending_exp.size() == 0) else begin
         $display("%0d reads never returned data", pending_exp.size());
         errors++;
      end
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
   output logic clk
);

   // period 4, first rising edge at 2
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

endmodule

`default_nettype wire
